/* source/flash_pkg.sv */
/* shared types and widths for the serial flash controller
   referenced by scoped name from the sequencer, timer, shifter and test model */
package flash_pkg;

	// ------------------------------------------------------------------------
	// sequencer states
	// ------------------------------------------------------------------------
	typedef enum logic [2:0] {
		reset,          // flash reset pin held active
		after_reset,    // device recovery time
		await_command,  // idle, waiting for a request
		write_command,  // opcode frame
		write_address,  // address frames, msb word first
		read_data,      // streaming words in
		write_data      // streaming words out
	} flash_state_e;

	// ------------------------------------------------------------------------
	// flash opcodes
	// ------------------------------------------------------------------------
	typedef enum logic [7:0] {
		cmd_write = 8'h02,  // page program
		cmd_read  = 8'h03   // normal read
	} flash_cmd_e;

	// delay counter width, enough for tens of us at 50 MHz
	localparam int WAIT_BITS = 16;

	// serial clock level between transfers
	// the model samples on its rising edges
	localparam logic SCLK_IDLE = 1'b1;

endpackage

/* source/wait_timer.sv */
/* down-counter for the flash reset and recovery delays
   load with a cycle count, done pulses once that many cycles later */
module wait_timer (
	input  logic in_clk,
	input  logic in_rst,
	input  logic load,
	input  logic [flash_pkg::WAIT_BITS-1:0] count,
	output logic done
);
	logic [flash_pkg::WAIT_BITS-1:0] ctr;
	logic running;

	// last counted cycle
	// a count of 0 behaves like 1
	assign done = running && (ctr <= flash_pkg::WAIT_BITS'(1));

	always_ff @(posedge in_clk or posedge in_rst) begin
		if (in_rst) begin
			ctr <= '0;
			running <= 1'b0;
		end else if (load) begin
			// a new load restarts, even on the done cycle
			ctr <= count;
			running <= 1'b1;
		end else if (done) begin
			running <= 1'b0;
		end else if (running) begin
			ctr <= ctr - 1'b1;
		end
	end

	// each done uses up its load
	// no second done before the next load
	assert property (@(posedge in_clk) disable iff (in_rst)
		(done && !load) |=> (!done until load));

endmodule

/* source/serial_shifter.sv */
/* serial clock divider and word shifter, msb first
   runs frames back to back while enable is high, latching tx_word at each start */
module serial_shifter #(
	parameter int WORD_BITS = 8,
	parameter int CLK_DIV   = 2
) (
	input  logic in_clk,
	input  logic in_rst,
	input  logic enable,
	input  logic [WORD_BITS-1:0] tx_word,
	output logic [WORD_BITS-1:0] rx_word,
	output logic word_done,
	output logic sclk,
	output logic sdo,
	input  logic sdi
);
	localparam int DIV_BITS = $clog2(CLK_DIV + 1);
	localparam int BIT_BITS = $clog2(WORD_BITS);

	logic active;
	logic sclk_q;
	logic done_q;
	logic [DIV_BITS-1:0] div_ctr;
	logic [BIT_BITS-1:0] bit_ctr;
	logic [WORD_BITS-1:0] tx_sr;
	logic [WORD_BITS-1:0] rx_sr;

	// ------------------------------------------------------------------------
	// edge timing
	// ------------------------------------------------------------------------
	logic half_end;
	logic last_bit;
	logic rise;
	logic fall;
	logic frame_start;

	// end of a half period
	assign half_end = (div_ctr == DIV_BITS'(CLK_DIV - 1));
	assign last_bit = (bit_ctr == BIT_BITS'(WORD_BITS - 1));

	// clock low half ends -> rising edge, sample here
	assign rise = enable && active && half_end && (sclk_q != flash_pkg::SCLK_IDLE);
	// clock high half ends -> falling edge, next bit out
	assign fall = enable && active && half_end && (sclk_q == flash_pkg::SCLK_IDLE);
	// first falling edge of a frame
	assign frame_start = enable && (!active || (fall && last_bit));

	// ------------------------------------------------------------------------
	// control
	// ------------------------------------------------------------------------
	always_ff @(posedge in_clk or posedge in_rst) begin
		if (in_rst) begin
			active <= 1'b0;
			sclk_q <= flash_pkg::SCLK_IDLE;
			done_q <= 1'b0;
			div_ctr <= '0;
			bit_ctr <= '0;
		end else begin
			done_q <= 1'b0;
			if (!enable) begin
				// abandon frame, clock back to idle
				active <= 1'b0;
				sclk_q <= flash_pkg::SCLK_IDLE;
				div_ctr <= '0;
				bit_ctr <= '0;
			end else if (!active) begin
				active <= 1'b1;
				sclk_q <= ~flash_pkg::SCLK_IDLE;
				div_ctr <= '0;
				bit_ctr <= '0;
			end else if (half_end) begin
				div_ctr <= '0;
				sclk_q <= ~sclk_q;
				// word complete after the last rising edge
				if (rise && last_bit)
					done_q <= 1'b1;
				if (fall)
					bit_ctr <= last_bit ? '0 : bit_ctr + 1'b1;
			end else begin
				div_ctr <= div_ctr + 1'b1;
			end
		end
	end

	// ------------------------------------------------------------------------
	// data shift registers
	// ------------------------------------------------------------------------
	always_ff @(posedge in_clk) begin
		if (frame_start)
			tx_sr <= tx_word;
		else if (fall)
			tx_sr <= {tx_sr[WORD_BITS-2:0], 1'b0};

		if (rise)
			rx_sr <= {rx_sr[WORD_BITS-2:0], sdi};
	end

	// done comes one half period before the next frame start,
	// which leaves the sequencer time to switch tx_word (needs CLK_DIV >= 2)
	assign word_done = done_q;
	assign rx_word = rx_sr;
	assign sclk = sclk_q;
	// data line low between frames
	assign sdo = active && tx_sr[WORD_BITS-1];

	// one cycle after enable is low the clock is idle
	assert property (@(posedge in_clk) disable iff (in_rst)
		!enable |=> (sclk == flash_pkg::SCLK_IDLE));

endmodule

/* source/flash_sequencer.sv */
/* request sequencer for the serial flash
   after the reset delays, sends opcode and address words, then streams data words */
module flash_sequencer #(
	parameter int WORD_BITS        = 8,
	parameter int ADDRESS_WORDS    = 2,
	parameter int WAIT_RESET       = 50,
	parameter int WAIT_AFTER_RESET = 1450
) (
	input  logic in_clk,
	input  logic in_rst,
	// user side
	input  logic in_enable,
	input  logic in_read,
	input  logic [WORD_BITS*ADDRESS_WORDS-1:0] in_addr,
	input  logic [WORD_BITS-1:0] in_data,
	output logic [WORD_BITS-1:0] out_data,
	output logic [WORD_BITS*ADDRESS_WORDS-1:0] out_word_ctr,
	output logic out_word_ready,
	// flash control, active high here
	output logic flash_reset,
	output logic write_unprotect,
	// delay timer
	output logic timer_load,
	output logic [flash_pkg::WAIT_BITS-1:0] timer_count,
	input  logic timer_done,
	// word shifter
	output logic shift_enable,
	output logic [WORD_BITS-1:0] tx_word,
	input  logic [WORD_BITS-1:0] rx_word,
	input  logic word_done
);
	localparam int CTR_BITS = WORD_BITS * ADDRESS_WORDS;

	flash_pkg::flash_state_e state, next_state;
	flash_pkg::flash_state_e data_state, next_data_state;
	flash_pkg::flash_cmd_e cmd, next_cmd;
	logic [CTR_BITS-1:0] word_ctr, next_word_ctr;
	logic word_ready, next_word_ready;
	logic timer_started;
	logic [CTR_BITS-1:0] addr_shifted;
	logic [WORD_BITS-1:0] addr_word;

	// ------------------------------------------------------------------------
	// current address word, msb word first
	// ------------------------------------------------------------------------
	assign addr_shifted = in_addr << (WORD_BITS * word_ctr);
	assign addr_word = addr_shifted[CTR_BITS-1 -: WORD_BITS];

	// ------------------------------------------------------------------------
	// registers
	// ------------------------------------------------------------------------
	always_ff @(posedge in_clk or posedge in_rst) begin
		if (in_rst) begin
			state <= flash_pkg::reset;
			data_state <= flash_pkg::read_data;
			cmd <= flash_pkg::cmd_read;
			word_ctr <= '0;
			word_ready <= 1'b0;
			timer_started <= 1'b0;
		end else begin
			state <= next_state;
			data_state <= next_data_state;
			cmd <= next_cmd;
			word_ctr <= next_word_ctr;
			word_ready <= next_word_ready;
			timer_started <= 1'b1;
		end
	end

	// received word, held until the next one
	always_ff @(posedge in_clk) begin
		if (state == flash_pkg::read_data && word_done)
			out_data <= rx_word;
	end

	// ------------------------------------------------------------------------
	// next state and outputs
	// ------------------------------------------------------------------------
	always_comb begin
		next_state = state;
		next_data_state = data_state;
		next_cmd = cmd;
		next_word_ctr = word_ctr;
		next_word_ready = 1'b0;
		timer_load = 1'b0;
		timer_count = flash_pkg::WAIT_BITS'(WAIT_AFTER_RESET);
		shift_enable = 1'b0;
		tx_word = addr_word;
		flash_reset = 1'b0;
		write_unprotect = 1'b0;

		case (state)
			flash_pkg::reset: begin
				flash_reset = 1'b1;
				// the load cycle is the first reset cycle
				if (!timer_started) begin
					timer_load = 1'b1;
					timer_count = flash_pkg::WAIT_BITS'(WAIT_RESET - 1);
				end
				// reload at once for the recovery wait
				if (timer_done) begin
					timer_load = 1'b1;
					next_state = flash_pkg::after_reset;
				end
			end

			flash_pkg::after_reset: begin
				if (timer_done)
					next_state = flash_pkg::await_command;
			end

			flash_pkg::await_command: begin
				if (in_enable) begin
					next_state = flash_pkg::write_command;
					next_word_ctr = '0;
					if (in_read) begin
						next_cmd = flash_pkg::cmd_read;
						next_data_state = flash_pkg::read_data;
					end else begin
						next_cmd = flash_pkg::cmd_write;
						next_data_state = flash_pkg::write_data;
					end
				end
			end

			flash_pkg::write_command: begin
				shift_enable = 1'b1;
				tx_word = WORD_BITS'(cmd);
				if (word_done)
					next_state = flash_pkg::write_address;
			end

			flash_pkg::write_address: begin
				shift_enable = 1'b1;
				if (word_done) begin
					if (word_ctr == CTR_BITS'(ADDRESS_WORDS - 1)) begin
						// counter restarts for the data words
						next_state = data_state;
						next_word_ctr = '0;
					end else begin
						next_word_ctr = word_ctr + 1'b1;
					end
				end
			end

			flash_pkg::read_data: begin
				shift_enable = 1'b1;
				if (word_done) begin
					next_word_ctr = word_ctr + 1'b1;
					next_word_ready = 1'b1;
				end
				if (!in_enable)
					next_state = flash_pkg::await_command;
			end

			flash_pkg::write_data: begin
				shift_enable = 1'b1;
				write_unprotect = 1'b1;
				tx_word = in_data;
				// ready asks for the next word
				if (word_done) begin
					next_word_ctr = word_ctr + 1'b1;
					next_word_ready = 1'b1;
				end
				if (!in_enable)
					next_state = flash_pkg::await_command;
			end

			default: begin
				next_state = flash_pkg::reset;
			end
		endcase
	end

	assign out_word_ctr = word_ctr;
	assign out_word_ready = word_ready;

	// unprotect only within a request that was latched as a write
	assert property (@(posedge in_clk) disable iff (in_rst)
		write_unprotect |-> (data_state == flash_pkg::write_data
			&& cmd == flash_pkg::cmd_write));

endmodule

/* source/flash_serial.sv */
/* top level of the serial flash controller
   joins sequencer, delay timer and shifter, drives the active-low flash pins */
module flash_serial #(
	parameter int WORD_BITS        = 8,
	parameter int ADDRESS_WORDS    = 2,
	parameter int MAIN_CLK         = 50_000_000,
	parameter int SERIAL_CLK       = 10_000_000,
	parameter int WAIT_RESET       = MAIN_CLK / 1_000_000,       // 1 us
	parameter int WAIT_AFTER_RESET = MAIN_CLK / 1_000_000 * 29   // 29 us
) (
	input  logic in_clk,
	input  logic in_rst,
	// user side
	input  logic in_enable,
	input  logic in_read,
	input  logic [WORD_BITS*ADDRESS_WORDS-1:0] in_addr,
	input  logic [WORD_BITS-1:0] in_data,
	output logic [WORD_BITS-1:0] out_data,
	output logic [WORD_BITS*ADDRESS_WORDS-1:0] out_word_ctr,
	output logic out_word_ready,
	// flash pins
	output logic out_flash_rst,
	output logic out_flash_clk,
	output logic out_flash_select,
	output logic out_flash_wp,
	output logic out_flash_data,
	input  logic in_flash_data
);
	// in_clk cycles per half serial period
	localparam int CLK_DIV = MAIN_CLK / (2 * SERIAL_CLK);

	logic flash_reset;
	logic write_unprotect;
	logic timer_load;
	logic [flash_pkg::WAIT_BITS-1:0] timer_count;
	logic timer_done;
	logic shift_enable;
	logic [WORD_BITS-1:0] tx_word;
	logic [WORD_BITS-1:0] rx_word;
	logic word_done;

	flash_sequencer #(
		.WORD_BITS(WORD_BITS), .ADDRESS_WORDS(ADDRESS_WORDS),
		.WAIT_RESET(WAIT_RESET), .WAIT_AFTER_RESET(WAIT_AFTER_RESET)
	) u_sequencer (
		.in_clk(in_clk), .in_rst(in_rst),
		.in_enable(in_enable), .in_read(in_read),
		.in_addr(in_addr), .in_data(in_data),
		.out_data(out_data), .out_word_ctr(out_word_ctr),
		.out_word_ready(out_word_ready),
		.flash_reset(flash_reset), .write_unprotect(write_unprotect),
		.timer_load(timer_load), .timer_count(timer_count), .timer_done(timer_done),
		.shift_enable(shift_enable), .tx_word(tx_word),
		.rx_word(rx_word), .word_done(word_done)
	);

	wait_timer u_timer (
		.in_clk(in_clk), .in_rst(in_rst),
		.load(timer_load), .count(timer_count), .done(timer_done)
	);

	serial_shifter #(
		.WORD_BITS(WORD_BITS), .CLK_DIV(CLK_DIV)
	) u_shifter (
		.in_clk(in_clk), .in_rst(in_rst),
		.enable(shift_enable), .tx_word(tx_word),
		.rx_word(rx_word), .word_done(word_done),
		.sclk(out_flash_clk), .sdo(out_flash_data), .sdi(in_flash_data)
	);

	// ------------------------------------------------------------------------
	// pins, reset and select active low
	// ------------------------------------------------------------------------
	assign out_flash_rst = ~flash_reset;
	assign out_flash_select = ~shift_enable;
	// write protect is active low, so high releases it
	assign out_flash_wp = write_unprotect;

endmodule

/* tests/flash_model.sv */
/* behavioral serial flash for the testbench, 8-bit words and a 16-bit address
   decodes opcode and address, returns memory bytes, reports every received word */
module flash_model (
	input  logic sclk,
	input  logic select_n,
	input  logic sdo,
	output logic sdi,
	// running count of completed words and the latest one
	output int rx_count,
	output logic [7:0] rx_word
);
	// opcode plus two address words
	localparam int HDR_WORDS = 3;

	logic [7:0] mem [0:65535];
	logic [7:0] sr;
	logic [15:0] addr;
	flash_pkg::flash_cmd_e cmd;
	int bit_cnt;
	int word_idx;

	initial begin
		// byte at a is low byte of a*7+5
		for (int a = 0; a < 65536; a++)
			mem[a] = 8'(a * 7 + 5);
		sdi = 1'b0;
		sr = '0;
		addr = '0;
		cmd = flash_pkg::cmd_write;
		bit_cnt = 0;
		word_idx = 0;
		rx_count = 0;
		rx_word = '0;
	end

	// deselect drops any partial word
	always @(posedge select_n) begin
		bit_cnt = 0;
		word_idx = 0;
	end

	// ------------------------------------------------------------------------
	// input side, sampled on rising sclk
	// ------------------------------------------------------------------------
	always @(posedge sclk) begin
		if (select_n === 1'b0) begin
			sr = {sr[6:0], sdo};
			bit_cnt++;
			if (bit_cnt == 8) begin
				if (word_idx == 0)
					cmd = flash_pkg::flash_cmd_e'(sr);
				else if (word_idx < HDR_WORDS)
					addr = {addr[7:0], sr};   // msb word first
				rx_word <= sr;
				rx_count <= rx_count + 1;
				word_idx++;
				bit_cnt = 0;
			end
		end
	end

	// read data changes on falling sclk, msb first
	always @(negedge sclk) begin
		if (select_n === 1'b0 && cmd == flash_pkg::cmd_read && word_idx >= HDR_WORDS)
			sdi <= mem[addr + 16'(word_idx - HDR_WORDS)][7 - bit_cnt];
		else
			sdi <= 1'b0;
	end

endmodule

/* tests/flash_checker.sv */
/* watches the controller ports and the flash model, compares with expected values
   counts checks and errors for the closing report of the testbench */
module flash_checker #(
	parameter int WAIT_RESET = 3
) (
	input  logic in_clk,
	input  logic in_rst,
	input  logic in_enable,
	input  logic in_read,
	input  logic [15:0] in_addr,
	input  logic [7:0] in_data,
	input  logic [7:0] out_data,
	input  logic [15:0] out_word_ctr,
	input  logic out_word_ready,
	input  logic out_flash_rst,
	input  logic out_flash_clk,
	input  logic out_flash_select,
	input  logic out_flash_wp,
	input  int model_count,
	input  logic [7:0] model_word,
	output int errors,
	output int checks
);
	logic [15:0] addr_q;
	logic read_q;
	logic select_q;
	logic enable_q;
	logic rst_done;
	int rst_cycles;
	int seen_count;
	int word_idx;
	int ready_count;
	// write words in the order the user offered them
	logic [7:0] wr_queue [$];

	// memory byte at addr+index, address wraps at 16 bits
	function automatic logic [7:0] expected_read(input logic [15:0] addr, input int index);
		logic [15:0] a;
		a = addr + 16'(index);
		return 8'(a * 16'd7 + 16'd5);
	endfunction

	task automatic report_error(input string msg);
		errors++;
		$display("FAILED at time %0t: %s", $time, msg);
	endtask

	task automatic check_that(input logic ok, input string msg);
		checks++;
		if (!ok)
			report_error(msg);
	endtask

	initial begin
		errors = 0;
		checks = 0;
		addr_q = '0;
		read_q = 1'b1;
		select_q = 1'b1;
		enable_q = 1'b1;
		rst_done = 1'b0;
		rst_cycles = 0;
		seen_count = 0;
		word_idx = 0;
		ready_count = 0;
	end

	// ------------------------------------------------------------------------
	// all values are the ones before the edge
	// ------------------------------------------------------------------------
	always @(posedge in_clk) begin
		if (in_rst) begin
			rst_cycles = 0;
			rst_done = 1'b0;
			select_q = 1'b1;
			enable_q = 1'b1;
			seen_count = model_count;
		end else begin
			// flash reset length, then never again
			if (!rst_done) begin
				if (!out_flash_rst) begin
					rst_cycles++;
				end else begin
					rst_done = 1'b1;
					check_that(rst_cycles == WAIT_RESET,
						$sformatf("flash reset low %0d cycles, expected %0d",
						rst_cycles, WAIT_RESET));
				end
			end else if (!out_flash_rst) begin
				report_error("flash reset pin went active again after the reset delay");
			end

			// transaction start, request fields stay put until the end
			if (select_q && !out_flash_select) begin
				addr_q = in_addr;
				read_q = in_read;
				word_idx = 0;
				ready_count = 0;
				wr_queue.delete();
				wr_queue.push_back(in_data);
			end

			// write protect released only in the write data phase
			if (out_flash_wp && (out_flash_select || read_q || word_idx < 3))
				report_error("write protect released outside the write data phase");
			if (!out_flash_select && !read_q && word_idx >= 3 && !out_flash_wp)
				report_error("write protect still active in the write data phase");

			// select must follow a dropped enable within one cycle
			if (!enable_q && !out_flash_select)
				report_error("select still active one cycle after enable dropped");
			if (select_q && out_flash_select && out_flash_clk !== 1'b1)
				report_error("serial clock not idle high between transfers");

			// words seen by the flash model
			if (model_count != seen_count) begin
				seen_count = model_count;
				if (word_idx == 0) begin
					check_that(model_word == (read_q ? 8'h03 : 8'h02),
						$sformatf("opcode %h, read=%0b", model_word, read_q));
				end else if (word_idx <= 2) begin
					check_that(model_word == (word_idx == 1 ? addr_q[15:8] : addr_q[7:0]),
						$sformatf("address word %0d is %h, addr %h",
						word_idx - 1, model_word, addr_q));
				end else if (!read_q) begin
					if (word_idx - 3 >= wr_queue.size())
						report_error("flash received a write word that was never offered");
					else
						check_that(model_word == wr_queue[word_idx - 3],
							$sformatf("write word %0d is %h, expected %h",
							word_idx - 3, model_word, wr_queue[word_idx - 3]));
				end
				word_idx++;
			end

			// ready pulse, next write word is already on in_data
			if (out_word_ready) begin
				if (read_q)
					check_that(out_data == expected_read(addr_q, ready_count),
						$sformatf("read word %0d at %h is %h, expected %h", ready_count,
						addr_q, out_data, expected_read(addr_q, ready_count)));
				check_that(out_word_ctr == 16'(ready_count + 1),
					$sformatf("word counter %0d, expected %0d", out_word_ctr, ready_count + 1));
				ready_count++;
				if (!read_q)
					wr_queue.push_back(in_data);
			end

			// transaction end
			if (!select_q && out_flash_select)
				check_that(word_idx - 3 == ready_count,
					$sformatf("flash saw %0d data words, %0d ready pulses",
					word_idx - 3, ready_count));

			select_q = out_flash_select;
			enable_q = in_enable;
		end
	end

endmodule

/* tests/tb_flash_serial.sv */
/* testbench for the serial flash controller
   directed and random read and write transactions against a flash model */
module tb_flash_serial;
	localparam int MAIN_CLK = 50_000_000;
	localparam int SERIAL_CLK = 10_000_000;
	localparam int WAIT_RESET = 3;
	localparam int WAIT_AFTER_RESET = 5;
	localparam int NUM_TXN = 12;
	localparam int MAX_WORDS = 6;
	// in_clk cycles per 8-bit frame
	localparam int FRAME_CYCLES = 8 * MAIN_CLK / SERIAL_CLK;
	localparam int CYCLE_LIMIT = NUM_TXN * (3 + MAX_WORDS) * FRAME_CYCLES
		+ 4 + WAIT_RESET + WAIT_AFTER_RESET + NUM_TXN * 20 + 200;

	logic in_clk;
	logic in_rst;
	logic in_enable;
	logic in_read;
	logic [15:0] in_addr;
	logic [7:0] in_data;
	logic [7:0] out_data;
	logic [15:0] out_word_ctr;
	logic out_word_ready;
	logic out_flash_rst;
	logic out_flash_clk;
	logic out_flash_select;
	logic out_flash_wp;
	logic out_flash_data;
	logic in_flash_data;
	int model_count;
	logic [7:0] model_word;
	int errors;
	int checks;
	int cycles;
	integer seed;

	flash_serial #(
		.MAIN_CLK(MAIN_CLK), .SERIAL_CLK(SERIAL_CLK),
		.WAIT_RESET(WAIT_RESET), .WAIT_AFTER_RESET(WAIT_AFTER_RESET)
	) u_dut (
		.in_clk(in_clk), .in_rst(in_rst),
		.in_enable(in_enable), .in_read(in_read),
		.in_addr(in_addr), .in_data(in_data),
		.out_data(out_data), .out_word_ctr(out_word_ctr),
		.out_word_ready(out_word_ready),
		.out_flash_rst(out_flash_rst), .out_flash_clk(out_flash_clk),
		.out_flash_select(out_flash_select), .out_flash_wp(out_flash_wp),
		.out_flash_data(out_flash_data), .in_flash_data(in_flash_data)
	);

	flash_model u_model (
		.sclk(out_flash_clk), .select_n(out_flash_select),
		.sdo(out_flash_data), .sdi(in_flash_data),
		.rx_count(model_count), .rx_word(model_word)
	);

	flash_checker #(
		.WAIT_RESET(WAIT_RESET)
	) u_checker (
		.in_clk(in_clk), .in_rst(in_rst),
		.in_enable(in_enable), .in_read(in_read),
		.in_addr(in_addr), .in_data(in_data),
		.out_data(out_data), .out_word_ctr(out_word_ctr),
		.out_word_ready(out_word_ready),
		.out_flash_rst(out_flash_rst), .out_flash_clk(out_flash_clk),
		.out_flash_select(out_flash_select), .out_flash_wp(out_flash_wp),
		.model_count(model_count), .model_word(model_word),
		.errors(errors), .checks(checks)
	);

	// ------------------------------------------------------------------------
	// clock and run limit
	// ------------------------------------------------------------------------
	always #5 in_clk = ~in_clk;

	always @(posedge in_clk) begin
		cycles++;
		if (cycles > CYCLE_LIMIT) begin
			$display("timeout: test sequence did not finish within %0d cycles", CYCLE_LIMIT);
			$display("tests failed");
			$finish;
		end
	end

	// one request, ends after the given number of data words
	task automatic run_transaction(input logic read, input int words);
		int got;
		got = 0;
		@(posedge in_clk);
		#1;
		in_read = read;
		in_addr = 16'($random(seed));
		in_data = 8'($random(seed));
		in_enable = 1'b1;
		while (got < words) begin
			@(posedge in_clk);
			#1;
			if (out_word_ready) begin
				got++;
				// ready asks for the next write word
				in_data = 8'($random(seed));
				if (got == words)
					in_enable = 1'b0;
			end
		end
		// idle gap until the flash is deselected
		while (!out_flash_select) begin
			@(posedge in_clk);
			#1;
		end
		repeat (2) @(posedge in_clk);
	endtask

	initial begin
		int words;
		logic read;
		seed = 32'h64e6_2df1;
		cycles = 0;
		in_clk = 1'b0;
		in_rst = 1'b1;
		in_enable = 1'b0;
		in_read = 1'b0;
		in_addr = '0;
		in_data = '0;
		repeat (4) @(posedge in_clk);
		#1;
		in_rst = 1'b0;

		// directed read then write, the rest random
		run_transaction(1'b1, 4);
		run_transaction(1'b0, 3);
		for (int t = 2; t < NUM_TXN; t++) begin
			read = $random(seed) & 1;
			words = 1 + (($random(seed) & 32'h7fff_ffff) % MAX_WORDS);
			run_transaction(read, words);
		end

		repeat (4) @(posedge in_clk);
		$display("checks: %0d, errors: %0d", checks, errors);
		if (errors == 0 && checks > 0)
			$display("all tests passed");
		else
			$display("tests failed");
		$finish;
	end

endmodule

/* all.f */
source/flash_pkg.sv
source/wait_timer.sv
source/serial_shifter.sv
source/flash_sequencer.sv
source/flash_serial.sv
tests/flash_model.sv
tests/flash_checker.sv
tests/tb_flash_serial.sv

/* Bender.yml */
package:
  name: flash_serial

sources:
  - source/flash_pkg.sv
  - source/wait_timer.sv
  - source/serial_shifter.sv
  - source/flash_sequencer.sv
  - source/flash_serial.sv
  - target: test
    files:
      - tests/flash_model.sv
      - tests/flash_checker.sv
      - tests/tb_flash_serial.sv
